/* bit_width_reducer.sv */
`timescale 1ns/1ps
`default_nettype none

module bit_width_reducer
  import dw_pkg::*;
#(
  parameter int DIN_WIDTH  = BUS_WIDTH,
  parameter int DOUT_WIDTH = MID_WIDTH
) (
  input  wire logic                  CLK,
  input  wire logic                  RESETN,
  input  wire logic [DIN_WIDTH-1:0]  DIN,
  input  wire logic                  DIN_VALID,
  output logic      [DOUT_WIDTH-1:0] DOUT,
  output logic                       CONVERT_READY,
  output logic                       CONVERT_VALID,
  output logic                       OVERFLOW
);

  // Number of narrow slices in one wide word.
  localparam int RATIO     = DIN_WIDTH / DOUT_WIDTH;
  localparam int CNT_WIDTH = (RATIO > 1) ? clog2(RATIO) : 1;
  localparam int DEPTH     = RATIO + CONVERT_MARGIN;

  localparam logic [CNT_WIDTH-1:0] LAST_SLICE = CNT_WIDTH'(RATIO - 1);

  logic [DIN_WIDTH-1:0] fifo_dout;
  logic                 fifo_not_empty;
  logic                 fifo_full;
  logic                 fifo_drop;
  logic                 fifo_re;
  logic [CNT_WIDTH-1:0] slice_cnt;
  logic                 last_slice;

  // Whole words are buffered; the splitter works on the head entry.
  sync_fifo #(
    .WIDTH (DIN_WIDTH),
    .DEPTH (DEPTH)
  ) u_fifo (
    .CLK       (CLK),
    .RESETN    (RESETN),
    .DIN       (DIN),
    .WE        (DIN_VALID),
    .RE        (fifo_re),
    .DOUT      (fifo_dout),
    .NOT_EMPTY (fifo_not_empty),
    .FULL      (fifo_full),
    .DROP      (fifo_drop)
  );

  assign last_slice = (slice_cnt == LAST_SLICE);

  // Pop the head on the cycle its last slice goes out.
  assign fifo_re = fifo_not_empty && last_slice;

  // A slice is presented whenever a word is waiting.
  assign CONVERT_VALID = fifo_not_empty;

  // Lowest slice first.
  assign DOUT = fifo_dout[slice_cnt * DOUT_WIDTH +: DOUT_WIDTH];

  // Walks across the head word, one slice per valid cycle.
  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      slice_cnt <= '0;
    end else if (fifo_not_empty) begin
      if (last_slice) begin
        slice_cnt <= '0; // Next word starts at slice 0.
      end else begin
        slice_cnt <= slice_cnt + 1'b1;
      end
    end
  end

  // Ready lags the FIFO by a cycle, so it is only a hint to the
  // source, which must keep to one word per RATIO cycles.
  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      CONVERT_READY <= 1'b0;
    end else begin
      CONVERT_READY <= !fifo_full;
    end
  end

  // Sticky until reset, so a single lost word is never missed.
  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      OVERFLOW <= 1'b0;
    end else if (fifo_drop) begin
      OVERFLOW <= 1'b1;
    end
  end

endmodule : bit_width_reducer

`default_nettype wire

/* dw_pkg.sv */
`default_nettype none

package dw_pkg;

  // Stream widths along the datapath.
  localparam int BUS_WIDTH = 128; // Input word from the source.
  localparam int MID_WIDTH = 64;  // Between stage 1 and stage 2.
  localparam int OUT_WIDTH = 32;  // Output slice to the sink.

  // Each stage holds the split ratio worth of words plus this slack,
  // so a source at the allowed rate never sees a full FIFO.
  localparam int CONVERT_MARGIN = 2;

  // Ceiling of log base 2.
  // clog2(1) = 0, clog2(2) = 1, clog2(4) = 2, clog2(5) = 3.
  function automatic int clog2(input int value);
    int result;
    int rest;
    result = 0;
    rest   = value - 1;
    while (rest > 0) begin
      result = result + 1;
      rest   = rest >> 1;
    end
    return result;
  endfunction

endpackage : dw_pkg

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f vlog.f --top-module width_reduce_tb -o width_reduce_sim \
  > build.log 2>&1 \
  || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/width_reduce_sim > sim.log 2>&1 \
  || echo "Simulator returned an error status"

grep -q "All checks passed" sim.log \
  && { echo "Simulation PASSED"; exit 0; } \
  || { echo "Simulation FAILED, see sim.log"; exit 1; }

/* sync_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module sync_fifo
  import dw_pkg::*;
#(
  parameter int WIDTH = BUS_WIDTH,
  parameter int DEPTH = 4
) (
  input  wire logic             CLK,
  input  wire logic             RESETN,
  input  wire logic [WIDTH-1:0] DIN,
  input  wire logic             WE,
  input  wire logic             RE,
  output logic      [WIDTH-1:0] DOUT,
  output logic                  NOT_EMPTY,
  output logic                  FULL,
  output logic                  DROP
);

  localparam int PTR_WIDTH = (DEPTH > 1) ? clog2(DEPTH) : 1;
  localparam int CNT_WIDTH = clog2(DEPTH + 1);

  localparam logic [PTR_WIDTH-1:0] LAST_PTR  = PTR_WIDTH'(DEPTH - 1);
  localparam logic [CNT_WIDTH-1:0] FULL_CNT  = CNT_WIDTH'(DEPTH);

  logic [WIDTH-1:0]     mem [DEPTH];
  logic [PTR_WIDTH-1:0] wr_ptr;
  logic [PTR_WIDTH-1:0] rd_ptr;
  logic [CNT_WIDTH-1:0] count;
  logic [CNT_WIDTH-1:0] count_next;
  logic                 do_read;
  logic                 do_write;

  // A read only happens when there is something to read.
  assign do_read  = RE && NOT_EMPTY;
  // A full FIFO still takes a word if the head leaves on the same edge.
  assign do_write = WE && (!FULL || do_read);
  assign DROP     = WE && FULL && !do_read; // Word is lost this cycle.

  assign DOUT = mem[rd_ptr]; // Head entry, no read latency.

  always_comb begin
    case ({do_write, do_read})
      2'b10:   count_next = count + 1'b1;
      2'b01:   count_next = count - 1'b1;
      default: count_next = count; // Idle, or read and write together.
    endcase
  end

  // Storage array, written at the tail.
  always_ff @(posedge CLK) begin
    if (do_write) begin
      mem[wr_ptr] <= DIN;
    end
  end

  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      wr_ptr <= '0;
    end else if (do_write) begin
      // Explicit wrap keeps non power of two depths correct.
      wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      rd_ptr <= '0;
    end else if (do_read) begin
      rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
    end
  end

  // Flags are registered from the next occupancy, so they
  // are exact on the cycle after each edge.
  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      count     <= '0;
      NOT_EMPTY <= 1'b0;
      FULL      <= 1'b0;
    end else begin
      count     <= count_next;
      NOT_EMPTY <= (count_next != '0);
      FULL      <= (count_next == FULL_CNT);
    end
  end

endmodule : sync_fifo

`default_nettype wire

/* vlog.f */
dw_pkg.sv
sync_fifo.sv
bit_width_reducer.sv
width_reduce_top.sv
width_reduce_assertions.sv
width_reduce_tb.sv

/* width_reduce_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module width_reduce_assertions (
  input wire logic CLK,
  input wire logic RESETN,
  input wire logic DOUT_VALID,
  input wire logic DIN_READY,
  input wire logic OVERFLOW
);

  // Output stays quiet from the second reset edge on.
  a_quiet_in_reset : assert property (
    @(posedge CLK) (!RESETN && $past(!RESETN)) |-> !DOUT_VALID
  ) else $error("DOUT_VALID high while the pipeline is held in reset");

  // Overflow is sticky.
  a_overflow_sticky : assert property (
    @(posedge CLK) (RESETN && $past(RESETN) && $past(OVERFLOW)) |-> OVERFLOW
  ) else $error("OVERFLOW fell without a reset");

  // Ready is registered, so it is still low in the first cycle out of reset.
  a_ready_after_reset : assert property (
    @(posedge CLK) $rose(RESETN) |-> !DIN_READY
  ) else $error("DIN_READY high in the first cycle after reset");

endmodule : width_reduce_assertions

bind width_reduce_top width_reduce_assertions u_protocol_check (
  .CLK        (CLK),
  .RESETN     (RESETN),
  .DOUT_VALID (DOUT_VALID),
  .DIN_READY  (DIN_READY),
  .OVERFLOW   (OVERFLOW)
);

`default_nettype wire

/* width_reduce_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module width_reduce_tb
  import dw_pkg::*;
();

  localparam int PH_SINGLE  = 1;
  localparam int PH_STREAM  = 2;
  localparam int PH_RANDOM  = 3;
  localparam int PH_BURST   = 4;
  localparam int PH_RECOVER = 5;
  localparam int NUM_ROWS   = 45;
  localparam int IDLE_DONE  = 8; // Quiet output cycles that end a phase.

  logic                 CLK;
  logic                 RESETN;
  logic [BUS_WIDTH-1:0] DIN;
  logic                 DIN_VALID;
  logic [OUT_WIDTH-1:0] DOUT;
  logic                 DOUT_VALID;
  logic                 DIN_READY;
  logic                 OVERFLOW;

  int                   tag_tab  [NUM_ROWS];
  int                   gap_tab  [NUM_ROWS];
  logic [BUS_WIDTH-1:0] word_tab [NUM_ROWS];

  logic [OUT_WIDTH-1:0] exp_q [$];       // Reference model output.
  logic [OUT_WIDTH-1:0] seen_q [$];      // Burst output for the order check.
  logic [BUS_WIDTH-1:0] burst_words [$];

  integer seed;
  int     errors;
  int     checks;
  int     tests_run;
  int     tests_failed;
  int     cycle_count;
  int     limit;
  int     first_valid;
  int     last_valid;
  int     accept_cycle;
  bit     collect;

  width_reduce_top uut (
    .CLK        (CLK),
    .RESETN     (RESETN),
    .DIN        (DIN),
    .DIN_VALID  (DIN_VALID),
    .DOUT       (DOUT),
    .DOUT_VALID (DOUT_VALID),
    .DIN_READY  (DIN_READY),
    .OVERFLOW   (OVERFLOW)
  );

  initial CLK = 1'b0;
  always #2 CLK = ~CLK; // 4 ns period.

  always @(posedge CLK) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= limit) begin
      $display("Run timed out after %0d cycles, the output never went quiet", cycle_count);
      $display("Checks failed");
      $finish;
    end
  end

  task automatic expect_true(input bit cond, input string what);
    checks++;
    assert (cond) else begin
      $display("[ERROR] %0t: %s", $time, what);
      errors++;
    end
  endtask

  task automatic compare_slice(input logic [OUT_WIDTH-1:0] expected);
    checks++;
    assert (DOUT === expected) else begin
      $display("[ERROR] %0t: DOUT expected %h, got %h", $time, expected, DOUT);
      errors++;
    end
  endtask

  // Sampled on the rising edge, where outputs are stable.
  always @(posedge CLK) begin
    if (RESETN && DOUT_VALID) begin
      if (first_valid < 0) begin
        first_valid = cycle_count;
      end
      last_valid = cycle_count;
      if (collect) begin
        seen_q.push_back(DOUT);
      end else begin
        checks++;
        assert (exp_q.size() > 0) else begin
          $display("[ERROR] %0t: slice %h came out with none expected", $time, DOUT);
          errors++;
        end
        if (exp_q.size() > 0) begin
          compare_slice(exp_q.pop_front());
        end
      end
    end
  end

  // Lowest 32 bits leave first.
  task automatic push_slices(input logic [BUS_WIDTH-1:0] word);
    for (int k = 0; k < BUS_WIDTH / OUT_WIDTH; k++) begin
      exp_q.push_back(word[k*OUT_WIDTH +: OUT_WIDTH]);
    end
  endtask

  function automatic string phase_name(input int tag);
    case (tag)
      PH_SINGLE: return "single word";
      PH_STREAM: return "streaming";
      PH_RANDOM: return "random gaps";
      PH_BURST:  return "overflow burst";
      default:   return "recovery";
    endcase
  endfunction

  task automatic report_test(input string name, input int err_start);
    tests_run++;
    if (errors == err_start) begin
      $display("Test %0d %s: passed", tests_run, name);
    end else begin
      tests_failed++;
      $display("Test %0d %s: failed with %0d errors", tests_run, name, errors - err_start);
    end
  endtask

  task automatic apply_reset(input bit check);
    @(negedge CLK);
    RESETN    = 1'b0;
    DIN_VALID = 1'b0;
    repeat (8) begin
      @(negedge CLK);
      if (check) begin
        expect_true(!DOUT_VALID && !OVERFLOW && !DIN_READY, "outputs not cleared in reset");
      end
    end
    RESETN = 1'b1;
    @(posedge CLK);
    if (check) begin
      expect_true(!DIN_READY && !DOUT_VALID && !OVERFLOW,
                  "outputs not low in the first cycle after reset");
    end
    @(posedge CLK);
    if (check) begin
      expect_true(DIN_READY, "DIN_READY low in the second cycle after reset");
    end
  endtask

  task automatic wait_idle();
    int idle;
    idle = 0;
    while (idle < IDLE_DONE) begin
      @(posedge CLK);
      if (DOUT_VALID) begin
        idle = 0;
      end else begin
        idle++;
      end
    end
  endtask

  // Stage 2 fills while stage 1 drains and can drop one 64-bit half,
  // so the burst is checked as halves of burst words in rising order.
  task automatic check_burst();
    int next_half;
    int k;
    bit found;
    logic [MID_WIDTH-1:0] pair;
    next_half = 0;
    expect_true(OVERFLOW, "OVERFLOW not set by the burst");
    expect_true(seen_q.size() > 0 && seen_q.size() % 2 == 0, "burst output not in 64-bit halves");
    while (seen_q.size() >= 2) begin
      pair = {seen_q[1], seen_q[0]};
      void'(seen_q.pop_front());
      void'(seen_q.pop_front());
      found = 1'b0;
      for (k = next_half; k < 2 * burst_words.size() && !found; k++) begin
        if (burst_words[k/2][(k%2)*MID_WIDTH +: MID_WIDTH] == pair) begin
          found     = 1'b1;
          next_half = k + 1;
        end
      end
      expect_true(found, "burst output out of order or not from the burst");
    end
  endtask

  task automatic start_phase(input int tag);
    if (tag == PH_RECOVER) begin
      apply_reset(1'b0);
      expect_true(!OVERFLOW && !DOUT_VALID, "reset did not clear the pipeline");
    end
    exp_q.delete();
    seen_q.delete();
    collect     = (tag == PH_BURST);
    first_valid = -1;
  endtask

  task automatic finish_phase(input int tag, input int err_start);
    @(negedge CLK);
    DIN_VALID = 1'b0;
    wait_idle();
    if (tag == PH_BURST) begin
      check_burst();
    end else begin
      expect_true(exp_q.size() == 0, "expected slices never came out");
      expect_true(!OVERFLOW, "OVERFLOW set at the allowed input rate");
    end
    if (tag == PH_SINGLE) begin
      expect_true(first_valid == accept_cycle + 2 && last_valid == accept_cycle + 5,
                  "single word slices off their fixed cycles");
    end
    report_test(phase_name(tag), err_start);
  endtask

  task automatic drive_row(input int i);
    repeat (gap_tab[i]) begin
      @(negedge CLK);
      DIN_VALID = 1'b0;
    end
    @(negedge CLK);
    DIN       = word_tab[i];
    DIN_VALID = 1'b1;
    if (tag_tab[i] == PH_BURST) begin
      burst_words.push_back(word_tab[i]);
    end else begin
      push_slices(word_tab[i]);
    end
    accept_cycle = cycle_count; // Taken on the next rising edge.
  endtask

  task automatic build_table();
    for (int i = 0; i < NUM_ROWS; i++) begin
      word_tab[i] = {$random(seed), $random(seed), $random(seed), $random(seed)};
      if (i == 0) begin
        tag_tab[i] = PH_SINGLE;
        gap_tab[i] = 2;
      end else if (i <= 16) begin
        tag_tab[i] = PH_STREAM;
        gap_tab[i] = 3;                          // One word every four cycles.
      end else if (i <= 28) begin
        tag_tab[i] = PH_RANDOM;
        gap_tab[i] = 4 + int'($unsigned($random(seed)) % 32'd5);
      end else if (i <= 40) begin
        tag_tab[i] = PH_BURST;
        gap_tab[i] = 0;                          // Back to back.
      end else begin
        tag_tab[i] = PH_RECOVER;
        gap_tab[i] = 3;
      end
    end
  endtask

  initial begin
    int cur;
    int err_start;
    int sum_gap;
    RESETN      = 1'b0;
    DIN         = '0;
    DIN_VALID   = 1'b0;
    seed        = 32'h1405c48f;
    errors      = 0;
    checks      = 0;
    tests_run   = 0;
    tests_failed = 0;
    cycle_count = 0;
    collect     = 1'b0;
    first_valid = -1;
    last_valid  = -1;
    accept_cycle = 0;
    build_table();
    sum_gap = 0;
    for (int i = 0; i < NUM_ROWS; i++) begin
      sum_gap += gap_tab[i];
    end
    // Gaps, four cycles per word, margin, two resets and a drain per phase.
    limit = sum_gap + 4 * NUM_ROWS + 100 + 2 * 10 + 6 * (IDLE_DONE + 2);

    err_start = errors;
    apply_reset(1'b1);
    report_test("reset", err_start);

    cur = 0;
    for (int i = 0; i < NUM_ROWS; i++) begin
      if (tag_tab[i] != cur) begin
        if (cur != 0) begin
          finish_phase(cur, err_start);
        end
        err_start = errors;
        start_phase(tag_tab[i]);
        cur = tag_tab[i];
      end
      drive_row(i);
    end
    finish_phase(cur, err_start);

    $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule : width_reduce_tb

`default_nettype wire

/* width_reduce_top.sv */
`timescale 1ns/1ps
`default_nettype none

module width_reduce_top
  import dw_pkg::*;
(
  input  wire logic                 CLK,
  input  wire logic                 RESETN,
  input  wire logic [BUS_WIDTH-1:0] DIN,
  input  wire logic                 DIN_VALID,
  output logic      [OUT_WIDTH-1:0] DOUT,
  output logic                      DOUT_VALID,
  output logic                      DIN_READY,
  output logic                      OVERFLOW
);

  logic [MID_WIDTH-1:0] mid_data;     // Stage 1 slice into stage 2.
  logic                 mid_valid;
  logic                 stage1_overflow;
  logic                 stage2_overflow;

  // 128 to 64 bits.
  bit_width_reducer #(
    .DIN_WIDTH  (BUS_WIDTH),
    .DOUT_WIDTH (MID_WIDTH)
  ) u_stage1 (
    .CLK           (CLK),
    .RESETN        (RESETN),
    .DIN           (DIN),
    .DIN_VALID     (DIN_VALID),
    .DOUT          (mid_data),
    .CONVERT_READY (DIN_READY),
    .CONVERT_VALID (mid_valid),
    .OVERFLOW      (stage1_overflow)
  );

  // 64 to 32 bits. Stage 1 has no stall input, so the
  // ready of this stage has nowhere to go.
  bit_width_reducer #(
    .DIN_WIDTH  (MID_WIDTH),
    .DOUT_WIDTH (OUT_WIDTH)
  ) u_stage2 (
    .CLK           (CLK),
    .RESETN        (RESETN),
    .DIN           (mid_data),
    .DIN_VALID     (mid_valid),
    .DOUT          (DOUT),
    .CONVERT_READY (),
    .CONVERT_VALID (DOUT_VALID),
    .OVERFLOW      (stage2_overflow)
  );

  assign OVERFLOW = stage1_overflow || stage2_overflow; // Either stage lost data.

endmodule : width_reduce_top

`default_nettype wire
